// ==== files.f ====
common/cpuPkg.sv
control/controlFsm.sv
rtl/pcUnit.sv
rtl/instrRegs.sv
rtl/regFile.sv
rtl/aluStage.sv
rtl/mipsCore.sv
verif/controlFsm_checker.sv
verif/mipsCore_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build
if ! verilator --binary --assert -Wno-fatal --top-module mipsCore_tb -f files.f -Mdir build/obj; then
	echo "build failed"
	exit 1
fi
./build/obj/VmipsCore_tb +verilator+error+limit+1000 > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Simulation failed" build/sim.log; then
	exit 1
fi
if ! grep -q "Simulation passed" build/sim.log; then
	echo "no result line in the log"
	exit 1
fi
exit 0

// ==== verif/mipsCore_tb.sv ====
// Multicycle core testbench
module mipsCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int writeTimeout = 200; // cycles per expected write
	localparam int idleCycles = 30;

	logic clock = 1'b0;
	logic arstN;
	logic [31:0] memReadData;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic memWrite;
	logic [31:0] mem [256];
	logic [31:0] lfsr = 32'h9d33;
	logic [7:0] progPtr;
	logic [31:0] wrAddrQ [$];
	logic [31:0] wrDataQ [$];
	int wrEdgeQ [$];
	logic [31:0] expAddrQ [$];
	logic [31:0] expDataQ [$];
	logic [31:0] watchAddr;
	int fetchEdge;
	int lastWriteEdge;
	int cycleCount = 0;
	int valueErrors = 0;
	int writeErrors = 0;
	int checkerFails;

	mipsCore dut_i (
		.clock(clock), .arstN(arstN), .memReadData(memReadData),
		.memAddr(memAddr), .memWriteData(memWriteData), .memWrite(memWrite)
	);

	always #5 clock = ~clock;

	always @(posedge clock) cycleCount++;

	assign memReadData = mem[memAddr[9:2]]; // word addressed

	always @(posedge clock) begin
		if (arstN && memWrite) mem[memAddr[9:2]] <= memWriteData;
	end

	// sampled mid cycle where the core outputs are settled
	always @(negedge clock) begin
		if (arstN && memWrite) begin
			wrAddrQ.push_back(memAddr);
			wrDataQ.push_back(memWriteData);
			wrEdgeQ.push_back(cycleCount + 1); // edge that commits it
		end
		if (arstN && memAddr == watchAddr && fetchEdge < 0) fetchEdge = cycleCount;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] addiWord(input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		return {6'd8, rs, rt, imm};
	endfunction

	function automatic logic [31:0] lwWord(input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] offset);
		return {6'd35, rs, rt, offset};
	endfunction

	function automatic logic [31:0] swWord(input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] offset);
		return {6'd43, rs, rt, offset};
	endfunction

	function automatic logic [31:0] branchWord(input logic isBne, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] offset);
		return {(isBne ? 6'd5 : 6'd4), rs, rt, offset};
	endfunction

	function automatic logic [31:0] rWord(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] funct);
		return {6'd0, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [25:0] index);
		return {6'd2, index};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[progPtr] <= word;
		progPtr++;
	endtask

	task automatic haltHere();
		emit(jumpWord({18'd0, progPtr})); // jump to itself
	endtask

	task automatic expectWrite(input logic [31:0] addr, input logic [31:0] data);
		expAddrQ.push_back(addr);
		expDataQ.push_back(data);
	endtask

	task automatic startReset();
		@(posedge clock);
		#1;
		arstN = 1'b0;
		wrAddrQ.delete();
		wrDataQ.delete();
		wrEdgeQ.delete();
		expAddrQ.delete();
		expDataQ.delete();
		watchAddr = '1;
		fetchEdge = -1;
		for (int i = 0; i < 256; i++) begin
			mem[i] <= {6'h3f, 2'b00, i[7:0], ~i[7:0], i[7:0]}; // unknown opcode if run
		end
		progPtr = '0;
	endtask

	task automatic releaseReset();
		repeat (16) @(posedge clock);
		#1;
		arstN = 1'b1;
	endtask

	task automatic checkWrites(input string name);
		int waited;
		logic [31:0] gotAddr;
		logic [31:0] gotData;
		while (expAddrQ.size() > 0) begin
			waited = 0;
			while (wrAddrQ.size() == 0 && waited < writeTimeout) begin
				@(posedge clock);
				waited++;
			end
			if (wrAddrQ.size() == 0) begin
				$display("ERROR %s: no memory write to %h came within %0d cycles",
					name, expAddrQ[0], writeTimeout);
				writeErrors++;
				expAddrQ.delete();
				expDataQ.delete();
			end else begin
				gotAddr = wrAddrQ.pop_front();
				gotData = wrDataQ.pop_front();
				lastWriteEdge = wrEdgeQ.pop_front();
				assert (gotAddr == expAddrQ[0]) else begin
					$display("FAILED %s: address expected %h actual %h",
						name, expAddrQ[0], gotAddr);
					valueErrors++;
				end
				assert (gotData == expDataQ[0]) else begin
					$display("FAILED %s: data expected %h actual %h",
						name, expDataQ[0], gotData);
					valueErrors++;
				end
				void'(expAddrQ.pop_front());
				void'(expDataQ.pop_front());
			end
		end
		repeat (idleCycles) @(posedge clock); // program is parked on its last jump
		assert (wrAddrQ.size() == 0) else begin
			$display("ERROR %s: %0d memory writes the program should not make",
				name, wrAddrQ.size());
			writeErrors++;
		end
	endtask

	task automatic arithTest();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] big;
		startReset();
		immA = randBits(16);
		immB = randBits(16);
		a = signExtend(immA);
		b = signExtend(immB);
		big = {2'b01, 30'(randBits(30))}; // doubling this overflows
		mem[8'hc0] <= big;
		emit(addiWord(5'd1, 5'd0, immA));
		emit(addiWord(5'd2, 5'd0, immB));
		emit(rWord(5'd3, 5'd1, 5'd2, 6'd32)); // add
		emit(rWord(5'd4, 5'd1, 5'd2, 6'd34)); // sub
		emit(rWord(5'd5, 5'd1, 5'd2, 6'd36)); // and
		emit(rWord(5'd6, 5'd1, 5'd2, 6'd42)); // slt
		emit(lwWord(5'd7, 5'd0, 16'h0300));
		emit(rWord(5'd8, 5'd7, 5'd7, 6'd32));
		for (int r = 1; r <= 6; r++) begin
			emit(swWord(r[4:0], 5'd0, 16'h01fc + 16'(r * 4)));
		end
		emit(swWord(5'd8, 5'd0, 16'h0218));
		haltHere();
		expectWrite(32'h200, a);
		expectWrite(32'h204, b);
		expectWrite(32'h208, a + b);
		expectWrite(32'h20c, a - b);
		expectWrite(32'h210, a & b);
		expectWrite(32'h214, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		expectWrite(32'h218, big + big); // wraps
		releaseReset();
		checkWrites("arith");
	endtask

	task automatic loadStoreTest();
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] d2;
		startReset();
		d0 = randBits(32);
		d1 = randBits(32);
		d2 = randBits(32);
		mem[8'hc0] <= d0;
		mem[8'hc1] <= d1;
		mem[8'hc2] <= d2;
		emit(lwWord(5'd1, 5'd0, 16'h0300));
		emit(lwWord(5'd2, 5'd0, 16'h0304));
		emit(addiWord(5'd10, 5'd0, 16'h0300));
		emit(lwWord(5'd3, 5'd10, 16'h0008));
		emit(swWord(5'd1, 5'd0, 16'h0280)); // offset only
		emit(swWord(5'd2, 5'd10, 16'hff84)); // negative offset, 0x284
		emit(swWord(5'd3, 5'd0, 16'h0288));
		haltHere();
		expectWrite(32'h280, d0);
		expectWrite(32'h284, d1);
		expectWrite(32'h288, d2);
		releaseReset();
		checkWrites("load store");
	endtask

	task automatic zeroRegTest();
		logic [15:0] imm;
		startReset();
		imm = randBits(16) | 16'h0001; // never zero
		emit(addiWord(5'd0, 5'd0, imm));
		emit(swWord(5'd0, 5'd0, 16'h0200));
		emit(addiWord(5'd1, 5'd0, imm));
		emit(rWord(5'd0, 5'd1, 5'd1, 6'd32));
		emit(swWord(5'd0, 5'd0, 16'h0204));
		emit(swWord(5'd1, 5'd0, 16'h0208));
		haltHere();
		expectWrite(32'h200, 32'd0);
		expectWrite(32'h204, 32'd0);
		expectWrite(32'h208, signExtend(imm));
		releaseReset();
		checkWrites("zero register");
	endtask

	// r1 against rt, the marker lives in r5
	task automatic branchCase(input logic isBne, input logic [4:0] rt, input logic [31:0] x,
		input logic [31:0] y, input logic [15:0] slotAddr, input logic [31:0] marker);
		logic taken;
		taken = isBne ? (x != y) : (x == y);
		emit(branchWord(isBne, 5'd1, rt, 16'd1)); // skips one word when taken
		emit(swWord(5'd5, 5'd0, slotAddr));
		emit(swWord(5'd5, 5'd0, slotAddr + 16'd4));
		if (!taken) expectWrite({16'd0, slotAddr}, marker);
		expectWrite({16'd0, slotAddr + 16'd4}, marker);
	endtask

	task automatic branchTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] mark;
		startReset();
		a = randBits(16);
		b = randBits(16);
		if (b == a) b = ~a;
		mark = randBits(16);
		emit(addiWord(5'd1, 5'd0, a));
		emit(addiWord(5'd2, 5'd0, a));
		emit(addiWord(5'd3, 5'd0, b));
		emit(addiWord(5'd5, 5'd0, mark));
		branchCase(1'b0, 5'd2, signExtend(a), signExtend(a), 16'h0200, signExtend(mark));
		branchCase(1'b0, 5'd3, signExtend(a), signExtend(b), 16'h0210, signExtend(mark));
		branchCase(1'b1, 5'd3, signExtend(a), signExtend(b), 16'h0220, signExtend(mark));
		branchCase(1'b1, 5'd2, signExtend(a), signExtend(a), 16'h0230, signExtend(mark));
		haltHere();
		releaseReset();
		checkWrites("branch");
	endtask

	task automatic jumpTest();
		logic [15:0] mark;
		logic [31:0] junk;
		startReset();
		mark = randBits(16);
		junk = randBits(26);
		emit(addiWord(5'd5, 5'd0, mark));
		emit({6'h3f, junk[25:0]}); // unknown opcode
		emit(rWord(5'd6, 5'd5, 5'd5, 6'h3f)); // unknown funct, r6 stays zero
		emit(swWord(5'd5, 5'd0, 16'h0200));
		emit(jumpWord(26'd6));
		emit(swWord(5'd5, 5'd0, 16'h0204)); // skipped
		emit(swWord(5'd6, 5'd0, 16'h0208));
		haltHere();
		expectWrite(32'h200, signExtend(mark));
		expectWrite(32'h208, 32'd0);
		releaseReset();
		checkWrites("jump");
	endtask

	task automatic storeTimingTest();
		logic [15:0] imm;
		startReset();
		imm = randBits(16);
		emit(addiWord(5'd5, 5'd0, imm));
		emit(jumpWord(26'd8));
		progPtr = 8'd8;
		emit(swWord(5'd5, 5'd0, 16'h0200)); // at byte address 32
		haltHere();
		watchAddr = 32'd32;
		expectWrite(32'h200, signExtend(imm));
		releaseReset();
		checkWrites("store timing");
		if (fetchEdge < 0) begin
			$display("ERROR store timing: the fetch of the store was never seen");
			writeErrors++;
		end else begin
			assert (lastWriteEdge - fetchEdge == 4) else begin
				$display("FAILED store timing: edges from fetch expected 4 actual %0d",
					lastWriteEdge - fetchEdge);
				valueErrors++;
			end
		end
	endtask

	initial begin
		arstN = 1'b0;
		watchAddr = '1;
		fetchEdge = -1;
		arithTest();
		loadStoreTest();
		zeroRegTest();
		branchTest();
		jumpTest();
		storeTimingTest();
		checkerFails = dut_i.control_i.checker_i.failCount;
		$display("errors: %0d wrong values, %0d missing or extra writes, %0d checker failures",
			valueErrors, writeErrors, checkerFails);
		if (valueErrors + writeErrors + checkerFails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verif/controlFsm_checker.sv ====
// Control strobe checker
module controlFsm_checker (
	input logic          clock,
	input logic          arstN,
	input cpuPkg::stateT state,
	input logic          memWrite,
	input logic          irWrite,
	input logic          regWrite,
	input logic          pcWrite
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0; // read by the testbench at the end

	noWriteDuringFetch: assert property (@(posedge clock) disable iff (!arstN)
		!(memWrite && irWrite))
		else begin failCount++; $error("memWrite and irWrite high together"); end

	singleCycleStore: assert property (@(posedge clock) disable iff (!arstN)
		memWrite |=> !memWrite)
		else begin failCount++; $error("memWrite held longer than one cycle"); end

	regWriteInWriteback: assert property (@(posedge clock) disable iff (!arstN)
		regWrite |-> (state == cpuPkg::stLoadWriteback || state == cpuPkg::stAluWriteback))
		else begin failCount++; $error("regWrite outside a write-back state"); end

	// first cycle out of reset is a plain fetch
	fetchAfterReset: assert property (@(posedge clock)
		$rose(arstN) |-> (state == cpuPkg::stFetch && irWrite && pcWrite && !memWrite && !regWrite))
		else begin failCount++; $error("first cycle after reset is not a clean fetch"); end

endmodule

bind controlFsm controlFsm_checker checker_i (
	.clock(clock), .arstN(arstN), .state(state), .memWrite(memWrite),
	.irWrite(irWrite), .regWrite(regWrite), .pcWrite(pcWrite)
);

// ==== rtl/mipsCore.sv ====
// Multicycle MIPS core top
module mipsCore (
	input  logic                         clock,
	input  logic                         arstN,
	input  logic [cpuPkg::dataWidth-1:0] memReadData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWriteData,
	output logic                         memWrite
);

	cpuPkg::opcodeT opcode;
	cpuPkg::functT funct;
	cpuPkg::pcSourceT pcSource;
	cpuPkg::aluSrcAT aluSrcA;
	cpuPkg::aluSrcBT aluSrcB;
	cpuPkg::aluOpT aluOp;
	logic zero;
	logic pcWrite;
	logic addrFromAlu;
	logic irWrite;
	logic mdrWrite;
	logic abLoad;
	logic aluOutWrite;
	logic regWrite;
	logic regDst;
	logic memToReg;
	logic [cpuPkg::dataWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] instr;
	logic [cpuPkg::dataWidth-1:0] mdr;
	logic [cpuPkg::dataWidth-1:0] regA;
	logic [cpuPkg::dataWidth-1:0] regB;
	logic [cpuPkg::dataWidth-1:0] aluOutReg;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] readDataA;
	logic [cpuPkg::dataWidth-1:0] readDataB;

	assign memWriteData = regB; // store data comes from rt

	controlFsm control_i (
		.clock(clock), .arstN(arstN),
		.opcode(opcode), .funct(funct), .zero(zero),
		.pcWrite(pcWrite), .addrFromAlu(addrFromAlu), .irWrite(irWrite),
		.mdrWrite(mdrWrite), .abLoad(abLoad), .aluOutWrite(aluOutWrite),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg), .memWrite(memWrite),
		.pcSource(pcSource), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp)
	);

	pcUnit pc_i (
		.clock(clock), .arstN(arstN),
		.pcWrite(pcWrite), .pcSource(pcSource), .addrFromAlu(addrFromAlu),
		.aluResult(aluResult), .aluOutReg(aluOutReg),
		.jumpIndex(instr[cpuPkg::jumpIndexWidth-1:0]),
		.pc(pc), .memAddr(memAddr)
	);

	instrRegs regs_i (
		.clock(clock), .arstN(arstN),
		.irWrite(irWrite), .mdrWrite(mdrWrite), .abLoad(abLoad), .aluOutWrite(aluOutWrite),
		.memReadData(memReadData), .readDataA(readDataA), .readDataB(readDataB),
		.aluResult(aluResult),
		.instr(instr), .mdr(mdr), .regA(regA), .regB(regB), .aluOutReg(aluOutReg),
		.opcode(opcode), .funct(funct)
	);

	regFile regFile_i (
		.clock(clock), .arstN(arstN), .instr(instr),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
		.aluOutReg(aluOutReg), .mdr(mdr),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	aluStage alu_i (
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.pc(pc), .regA(regA), .regB(regB), .instr(instr),
		.aluResult(aluResult), .zero(zero)
	);

endmodule

// ==== rtl/aluStage.sv ====
// Operand select and ALU
module aluStage (
	input  cpuPkg::aluSrcAT              aluSrcA,
	input  cpuPkg::aluSrcBT              aluSrcB,
	input  cpuPkg::aluOpT                aluOp,
	input  logic [cpuPkg::dataWidth-1:0] pc,
	input  logic [cpuPkg::dataWidth-1:0] regA,
	input  logic [cpuPkg::dataWidth-1:0] regB,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] aluResult,
	output logic                         zero
);

	logic [cpuPkg::dataWidth-1:0] immExt;
	logic [cpuPkg::dataWidth-1:0] opA;
	logic [cpuPkg::dataWidth-1:0] opB;

	assign immExt = {{(cpuPkg::dataWidth-cpuPkg::immWidth){instr[cpuPkg::immWidth-1]}},
		instr[cpuPkg::immWidth-1:0]};

	assign opA = (aluSrcA == cpuPkg::srcARegA) ? regA : pc;

	always_comb begin
		case (aluSrcB)
			cpuPkg::srcBRegB:   opB = regB;
			cpuPkg::srcBImm:    opB = immExt;
			cpuPkg::srcBBranch: opB = immExt << 2; // word offset
			default:            opB = cpuPkg::dataWidth'(4);
		endcase
	end

	always_comb begin
		case (aluOp)
			cpuPkg::aluSub:     aluResult = opA - opB;
			cpuPkg::aluAnd:     aluResult = opA & opB;
			cpuPkg::aluSetLess: aluResult = {{(cpuPkg::dataWidth-1){1'b0}},
				$signed(opA) < $signed(opB)};
			default:            aluResult = opA + opB; // wraps, no overflow trap
		endcase
	end

	assign zero = (aluResult == '0);

endmodule

// ==== rtl/regFile.sv ====
// General register file
module regFile (
	input  logic                         clock,
	input  logic                         arstN,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	input  logic                         regWrite,
	input  logic                         regDst,
	input  logic                         memToReg,
	input  logic [cpuPkg::dataWidth-1:0] aluOutReg,
	input  logic [cpuPkg::dataWidth-1:0] mdr,
	output logic [cpuPkg::dataWidth-1:0] readDataA,
	output logic [cpuPkg::dataWidth-1:0] readDataB
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::regAddrWidth-1:0] writeAddr;
	logic [cpuPkg::dataWidth-1:0] writeData;

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	assign writeAddr = regDst ? rd : rt;
	assign writeData = memToReg ? mdr : aluOutReg; // load or alu result

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// r0 reads as zero whatever is stored
	assign readDataA = (rs == '0) ? '0 : regs[rs];
	assign readDataB = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== rtl/instrRegs.sv ====
// Datapath holding registers
module instrRegs (
	input  logic                         clock,
	input  logic                         arstN,
	input  logic                         irWrite,
	input  logic                         mdrWrite,
	input  logic                         abLoad,
	input  logic                         aluOutWrite,
	input  logic [cpuPkg::dataWidth-1:0] memReadData,
	input  logic [cpuPkg::dataWidth-1:0] readDataA,
	input  logic [cpuPkg::dataWidth-1:0] readDataB,
	input  logic [cpuPkg::dataWidth-1:0] aluResult,
	output logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] mdr,
	output logic [cpuPkg::dataWidth-1:0] regA,
	output logic [cpuPkg::dataWidth-1:0] regB,
	output logic [cpuPkg::dataWidth-1:0] aluOutReg,
	output cpuPkg::opcodeT               opcode,
	output cpuPkg::functT                funct
);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			instr <= '0;
			mdr <= '0;
			regA <= '0;
			regB <= '0;
			aluOutReg <= '0;
		end else begin
			if (irWrite) instr <= memReadData;
			if (mdrWrite) mdr <= memReadData;
			if (abLoad) begin
				regA <= readDataA;
				regB <= readDataB; // also the store data
			end
			if (aluOutWrite) aluOutReg <= aluResult;
		end
	end

	// codes outside the enums pass through unchanged
	assign opcode = cpuPkg::opcodeT'(instr[cpuPkg::dataWidth-1 -: cpuPkg::fieldWidth]);
	assign funct = cpuPkg::functT'(instr[cpuPkg::fieldWidth-1:0]);

endmodule

// ==== rtl/pcUnit.sv ====
// Program counter and address select
module pcUnit (
	input  logic                         clock,
	input  logic                         arstN,
	input  logic                         pcWrite,
	input  cpuPkg::pcSourceT             pcSource,
	input  logic                         addrFromAlu,
	input  logic [cpuPkg::dataWidth-1:0] aluResult,
	input  logic [cpuPkg::dataWidth-1:0] aluOutReg,
	input  logic [cpuPkg::jumpIndexWidth-1:0] jumpIndex,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] memAddr
);

	logic [cpuPkg::dataWidth-1:0] nextPc;
	logic [cpuPkg::dataWidth-1:0] jumpTarget;

	// region bits of the current pc, index is word aligned
	assign jumpTarget = {pc[cpuPkg::dataWidth-1:cpuPkg::jumpIndexWidth+2], jumpIndex, 2'b00};

	always_comb begin
		case (pcSource)
			cpuPkg::pcFromAluOut: nextPc = aluOutReg; // branch target
			cpuPkg::pcFromJump:   nextPc = jumpTarget;
			default:              nextPc = aluResult; // pc + 4
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	// data accesses use the computed address
	assign memAddr = addrFromAlu ? aluOutReg : pc;

endmodule

// ==== control/controlFsm.sv ====
// Multicycle control FSM
module controlFsm (
	input  logic              clock,
	input  logic              arstN,
	input  cpuPkg::opcodeT    opcode,
	input  cpuPkg::functT     funct,
	input  logic              zero,
	output logic              pcWrite,
	output logic              addrFromAlu,
	output logic              irWrite,
	output logic              mdrWrite,
	output logic              abLoad,
	output logic              aluOutWrite,
	output logic              regWrite,
	output logic              regDst,
	output logic              memToReg,
	output logic              memWrite,
	output cpuPkg::pcSourceT  pcSource,
	output cpuPkg::aluSrcAT   aluSrcA,
	output cpuPkg::aluSrcBT   aluSrcB,
	output cpuPkg::aluOpT     aluOp
);

	cpuPkg::stateT state;
	cpuPkg::stateT nextState;
	logic functKnown;

	assign functKnown = funct inside {cpuPkg::functAdd, cpuPkg::functSub,
		cpuPkg::functAnd, cpuPkg::functSlt};

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= cpuPkg::stFetch;
		end else begin
			state <= nextState;
		end
	end

	// strobes and next state, all decoded from the current state
	always_comb begin
		pcWrite = 1'b0;
		addrFromAlu = 1'b0;
		irWrite = 1'b0;
		mdrWrite = 1'b0;
		abLoad = 1'b0;
		aluOutWrite = 1'b0;
		regWrite = 1'b0;
		regDst = 1'b0; // rt by default
		memToReg = 1'b0;
		memWrite = 1'b0;
		pcSource = cpuPkg::pcFromAlu;
		aluSrcA = cpuPkg::srcAPc;
		aluSrcB = cpuPkg::srcBFour;
		aluOp = cpuPkg::aluAdd;
		nextState = cpuPkg::stFetch;

		case (state)
			cpuPkg::stFetch: begin
				irWrite = 1'b1;
				pcWrite = 1'b1; // pc + 4
				nextState = cpuPkg::stDecode;
			end
			cpuPkg::stDecode: begin
				abLoad = 1'b1;
				aluOutWrite = 1'b1; // precompute branch target
				aluSrcB = cpuPkg::srcBBranch;
				case (opcode)
					cpuPkg::opRType: nextState = functKnown ? cpuPkg::stExecute : cpuPkg::stFetch;
					cpuPkg::opAddi:  nextState = cpuPkg::stExecute;
					cpuPkg::opLw,
					cpuPkg::opSw:    nextState = cpuPkg::stMemAddr;
					cpuPkg::opBeq,
					cpuPkg::opBne:   nextState = cpuPkg::stBranch;
					cpuPkg::opJ:     nextState = cpuPkg::stJump;
					default:         nextState = cpuPkg::stFetch; // unknown, no effect
				endcase
			end
			cpuPkg::stMemAddr: begin
				aluSrcA = cpuPkg::srcARegA;
				aluSrcB = cpuPkg::srcBImm;
				aluOutWrite = 1'b1;
				nextState = (opcode == cpuPkg::opLw) ? cpuPkg::stMemRead : cpuPkg::stStoreWrite;
			end
			cpuPkg::stMemRead: begin
				addrFromAlu = 1'b1;
				mdrWrite = 1'b1;
				nextState = cpuPkg::stLoadWriteback;
			end
			cpuPkg::stLoadWriteback: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			cpuPkg::stStoreWrite: begin
				addrFromAlu = 1'b1;
				memWrite = 1'b1;
			end
			cpuPkg::stExecute: begin
				aluSrcA = cpuPkg::srcARegA;
				aluOutWrite = 1'b1;
				if (opcode == cpuPkg::opRType) begin
					aluSrcB = cpuPkg::srcBRegB;
					case (funct)
						cpuPkg::functSub: aluOp = cpuPkg::aluSub;
						cpuPkg::functAnd: aluOp = cpuPkg::aluAnd;
						cpuPkg::functSlt: aluOp = cpuPkg::aluSetLess;
						default:          aluOp = cpuPkg::aluAdd;
					endcase
				end else begin
					aluSrcB = cpuPkg::srcBImm; // addi
				end
				nextState = cpuPkg::stAluWriteback;
			end
			cpuPkg::stAluWriteback: begin
				regWrite = 1'b1;
				regDst = (opcode == cpuPkg::opRType); // rd for r-type
			end
			cpuPkg::stBranch: begin
				aluSrcA = cpuPkg::srcARegA;
				aluSrcB = cpuPkg::srcBRegB;
				aluOp = cpuPkg::aluSub; // compare A and B
				pcSource = cpuPkg::pcFromAluOut;
				pcWrite = (opcode == cpuPkg::opBeq) ? zero : !zero;
			end
			cpuPkg::stJump: begin
				pcSource = cpuPkg::pcFromJump;
				pcWrite = 1'b1;
			end
			default: begin
				nextState = cpuPkg::stFetch;
			end
		endcase
	end

endmodule

// ==== common/cpuPkg.sv ====
// Multicycle CPU definitions
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int numRegs = 32; // general registers
	localparam int fieldWidth = 6; // opcode and funct fields
	localparam int jumpIndexWidth = 26;
	localparam int immWidth = 16;

	// primary opcodes, instr[31:26]
	typedef enum logic [fieldWidth-1:0] {
		opRType = 6'd0,
		opJ     = 6'd2,
		opBeq   = 6'd4,
		opBne   = 6'd5,
		opAddi  = 6'd8,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeT;

	// r-type function codes, instr[5:0]
	typedef enum logic [fieldWidth-1:0] {
		functAdd = 6'd32,
		functSub = 6'd34,
		functAnd = 6'd36,
		functSlt = 6'd42
	} functT;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluSetLess
	} aluOpT;

	typedef enum logic {
		srcAPc,
		srcARegA
	} aluSrcAT;

	typedef enum logic [1:0] {
		srcBRegB,
		srcBFour,
		srcBImm,
		srcBBranch // immediate shifted left by two
	} aluSrcBT;

	typedef enum logic [1:0] {
		pcFromAlu,
		pcFromAluOut,
		pcFromJump
	} pcSourceT;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stMemAddr,
		stMemRead,
		stLoadWriteback,
		stStoreWrite,
		stExecute,
		stAluWriteback,
		stBranch,
		stJump
	} stateT;

endpackage
